//--- fifo_data_pkg.sv
// Data-path types: pixel word and item count.
package fifo_data_pkg;

  // Width of one pixel as it travels through the FIFO.
  localparam int PIXEL_W = 16;

  // Width of every occupancy count in the subsystem.
  // Sixteen bits cover a core of up to 2**15 entries plus the output stage.
  localparam int LEVEL_W = 16;

  // One pixel word, written by the producer and popped by the consumer.
  typedef logic [PIXEL_W-1:0] pixel_t;

  // Item count, used for the core fill level and the subsystem level.
  typedef logic [LEVEL_W-1:0] level_t;

endpackage

//--- fifo_cfg_pkg.sv
// Configuration bus types, register map and threshold reset value.
package fifo_cfg_pkg;

  localparam int CFG_ADDR_W = 4;  // Register address width.
  localparam int CFG_DATA_W = 16; // Register data width.

  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;

  // Command from the master. It is held stable while cfg_req is high.
  typedef struct packed {
    logic      write; // 1 for a write, 0 for a read.
    cfg_addr_t addr;
    cfg_data_t wdata;
  } cfg_req_t;

  // Response to the master, valid while cfg_ack is high.
  typedef struct packed {
    cfg_data_t rdata;
  } cfg_rsp_t;

  // Register map.
  localparam cfg_addr_t ADDR_THRESH = 4'd0; // Almost-full threshold, read-write.
  localparam cfg_addr_t ADDR_LEVEL  = 4'd1; // Subsystem occupancy, read-only.
  localparam cfg_addr_t ADDR_STATUS = 4'd2; // Sticky flags, write 1 to clear.

  // Bit of ADDR_STATUS that holds the sticky overflow flag.
  localparam int STATUS_OVF_BIT = 0;

  // Almost-full threshold after reset.
  localparam cfg_data_t THRESH_RESET = 16'd12;

endpackage

//--- fifo_ram.sv
// Simple dual-port pixel memory with a registered read port.
`timescale 1ns/100ps

module fifo_ram #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                     RD_CLK,
  input  logic                     wr_en,
  input  logic [DEPTH_LOG2-1:0]    wr_addr,
  input  fifo_data_pkg::pixel_t    wr_data,
  input  logic                     rd_en,
  input  logic [DEPTH_LOG2-1:0]    rd_addr,
  output fifo_data_pkg::pixel_t    rd_data
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  fifo_data_pkg::pixel_t mem [0:DEPTH-1];

  // Write port.
  always_ff @(posedge RD_CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // The read register only loads on rd_en, so the last word read stays on
  // rd_data until the next read. This matches a block RAM output latch.
  always_ff @(posedge RD_CLK) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- fifo_core.sv
// FIFO core: pointers, item count, hard full, overflow and RAM read control.
`timescale 1ns/100ps

module fifo_core #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                  RD_CLK,
  input  logic                  RESET,
  input  logic                  wren,
  input  fifo_data_pkg::pixel_t din,
  input  logic                  rd_en,
  output fifo_data_pkg::pixel_t dout,
  output logic                  empty,
  output logic                  hard_full,
  output logic                  overflow
);

  // Number of words the RAM can hold.
  localparam fifo_data_pkg::level_t DEPTH = fifo_data_pkg::level_t'(2 ** DEPTH_LOG2);

  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  fifo_data_pkg::level_t count;  // Words currently held in the RAM.
  logic                  accept; // Write taken into the RAM this cycle.

  // Both flags decode the registered count, so overflow below depends only
  // on wren and register state.
  assign empty     = (count == '0);
  assign hard_full = (count == DEPTH);

  assign accept   = wren && !hard_full;
  assign overflow = wren && hard_full; // The word on din is dropped.

  // Pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      count <= '0;
    end else begin
      case ({accept, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Idle, or a write and a read together.
      endcase
    end
  end

  fifo_ram #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) fifo_ram_inst (
    .RD_CLK  (RD_CLK),
    .wr_en   (accept),
    .wr_addr (wr_ptr),
    .wr_data (din),
    .rd_en   (rd_en),
    .rd_addr (rd_ptr),
    .rd_data (dout)
  );

  // The output stage must never pull from an empty core, or the pointers
  // would run past each other.
  a_no_read_when_empty : assert property (
    @(posedge RD_CLK) disable iff (RESET)
    !(rd_en && empty)
  ) else $error("fifo_core: read enable while the core is empty.");

endmodule

//--- fifo_out_stage.sv
// Prefetch output stage giving first-word-fall-through with registered dout and empty.
`timescale 1ns/100ps

module fifo_out_stage (
  input  logic                  RD_CLK,
  input  logic                  RESET,
  input  logic                  core_empty,
  input  fifo_data_pkg::pixel_t core_dout,
  output logic                  core_rd_en,
  input  logic                  rden,
  output fifo_data_pkg::pixel_t dout,
  output logic                  empty
);

  fifo_data_pkg::pixel_t middle_dout;

  // Three slots: the word on core_dout, the middle register and dout.
  logic fifo_valid;   // core_dout holds a word read in the previous cycle.
  logic middle_valid;
  logic dout_valid;

  logic will_update_middle;
  logic will_update_dout;

  // dout loads whenever a word is waiting and dout is free or being popped.
  assign will_update_dout = (middle_valid || fifo_valid) && (rden || !dout_valid);

  // The core word goes to the middle register when dout cannot take it
  // directly. That happens when middle is empty and dout is busy, or when
  // dout is taking the middle word this cycle.
  assign will_update_middle = fifo_valid && (middle_valid == will_update_dout);

  // Keep reading until every slot is occupied, so no word gets lost.
  assign core_rd_en = !core_empty && !(fifo_valid && middle_valid && dout_valid);

  assign empty = !dout_valid;

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      fifo_valid   <= 1'b0;
      middle_valid <= 1'b0;
      dout_valid   <= 1'b0;
    end else begin
      // A fresh read refills core_dout even if its old word moves on.
      if (core_rd_en) begin
        fifo_valid <= 1'b1;
      end else if (will_update_middle || will_update_dout) begin
        fifo_valid <= 1'b0;
      end

      if (will_update_middle) begin
        middle_valid <= 1'b1;
      end else if (will_update_dout) begin
        middle_valid <= 1'b0; // Middle word moved to dout.
      end

      if (will_update_dout) begin
        dout_valid <= 1'b1;
      end else if (rden) begin
        dout_valid <= 1'b0;
      end
    end
  end

  // Data registers follow the valid flags above.
  always_ff @(posedge RD_CLK) begin
    if (will_update_middle) begin
      middle_dout <= core_dout;
    end
    if (will_update_dout) begin
      dout <= middle_valid ? middle_dout : core_dout; // Older word first.
    end
  end

  // A word on dout that is not popped must stay there unchanged.
  a_hold_under_backpressure : assert property (
    @(posedge RD_CLK) disable iff (RESET)
    (!empty && !rden) |=> (!empty && $stable(dout))
  ) else $error("fifo_out_stage: dout changed while held.");

endmodule

//--- fifo_csr.sv
// Configuration register block: threshold, subsystem level, almost full, sticky overflow.
`timescale 1ns/100ps

module fifo_csr (
  input  logic                   RD_CLK,
  input  logic                   RESET,
  input  logic                   cfg_req,
  input  fifo_cfg_pkg::cfg_req_t cfg_cmd,
  output logic                   cfg_ack,
  output fifo_cfg_pkg::cfg_rsp_t cfg_rsp,
  input  logic                   wren,
  input  logic                   overflow,
  input  logic                   pop,
  output logic                   full
);

  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_REQ_LOW
  } state_t;

  state_t                  state;
  fifo_cfg_pkg::cfg_data_t thresh;
  fifo_data_pkg::level_t   level;
  logic                    ovf_sticky;
  logic                    access; // Single-cycle strobe for the bus access.
  logic                    write_acc;

  assign access    = (state == IDLE) && cfg_req;
  assign write_acc = access && cfg_cmd.write;

  // Acknowledge is a decode of the state register.
  assign cfg_ack = (state != IDLE);

  // Four-phase handshake.
  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:         if (cfg_req) state <= ACK;
        ACK:          state <= cfg_req ? WAIT_REQ_LOW : IDLE;
        WAIT_REQ_LOW: if (!cfg_req) state <= IDLE;
        default:      state <= IDLE;
      endcase
    end
  end

  // Read data is captured once per request and held until the next one.
  always_ff @(posedge RD_CLK) begin
    if (access) begin
      case (cfg_cmd.addr)
        fifo_cfg_pkg::ADDR_THRESH: cfg_rsp.rdata <= thresh;
        fifo_cfg_pkg::ADDR_LEVEL:  cfg_rsp.rdata <= level;
        fifo_cfg_pkg::ADDR_STATUS: begin
          cfg_rsp.rdata <= '0;
          cfg_rsp.rdata[fifo_cfg_pkg::STATUS_OVF_BIT] <= ovf_sticky;
        end
        default:                   cfg_rsp.rdata <= '0;
      endcase
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      thresh     <= fifo_cfg_pkg::THRESH_RESET;
      ovf_sticky <= 1'b0;
    end else begin
      if (write_acc && (cfg_cmd.addr == fifo_cfg_pkg::ADDR_THRESH)) begin
        thresh <= cfg_cmd.wdata;
      end
      // A new overflow wins over a clear in the same cycle.
      if (overflow) begin
        ovf_sticky <= 1'b1;
      end else if (write_acc && (cfg_cmd.addr == fifo_cfg_pkg::ADDR_STATUS)
                   && cfg_cmd.wdata[fifo_cfg_pkg::STATUS_OVF_BIT]) begin
        ovf_sticky <= 1'b0;
      end
    end
  end

  // Level covers the core and the output stage together.
  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      level <= '0;
      full  <= 1'b0;
    end else begin
      case ({wren && !overflow, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
      full <= (level >= thresh); // Lags the level by one cycle.
    end
  end

  // The master keeps its request up until it sees the acknowledge.
  a_ack_needs_req : assert property (
    @(posedge RD_CLK) disable iff (RESET)
    $rose(cfg_ack) |-> cfg_req
  ) else $error("fifo_csr: cfg_ack rose without a request.");

endmodule

//--- line_fifo_top.sv
// Line FIFO top level: core, prefetch output stage and register block.
`timescale 1ns/100ps

module line_fifo_top #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                   RD_CLK,
  input  logic                   RESET,
  input  logic                   wren,
  input  fifo_data_pkg::pixel_t  din,
  output logic                   overflow,
  input  logic                   rden,
  output fifo_data_pkg::pixel_t  dout,
  output logic                   empty,
  output logic                   full,
  input  logic                   cfg_req,
  output logic                   cfg_ack,
  input  fifo_cfg_pkg::cfg_req_t cfg_cmd,
  output fifo_cfg_pkg::cfg_rsp_t cfg_rsp
);

  logic                  core_rd_en;
  logic                  core_empty;
  fifo_data_pkg::pixel_t core_dout;
  logic                  pop; // A word leaves the subsystem.

  assign pop = rden && !empty;

  // Hard full only matters inside the core, where it drives overflow.
  fifo_core #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) fifo_core_inst (
    .RD_CLK    (RD_CLK),
    .RESET     (RESET),
    .wren      (wren),
    .din       (din),
    .rd_en     (core_rd_en),
    .dout      (core_dout),
    .empty     (core_empty),
    .hard_full (),
    .overflow  (overflow)
  );

  fifo_out_stage fifo_out_stage_inst (
    .RD_CLK     (RD_CLK),
    .RESET      (RESET),
    .core_empty (core_empty),
    .core_dout  (core_dout),
    .core_rd_en (core_rd_en),
    .rden       (rden),
    .dout       (dout),
    .empty      (empty)
  );

  fifo_csr fifo_csr_inst (
    .RD_CLK   (RD_CLK),
    .RESET    (RESET),
    .cfg_req  (cfg_req),
    .cfg_cmd  (cfg_cmd),
    .cfg_ack  (cfg_ack),
    .cfg_rsp  (cfg_rsp),
    .wren     (wren),
    .overflow (overflow),
    .pop      (pop),
    .full     (full)
  );

endmodule

//--- line_fifo_tb.sv
// Testbench for line_fifo_top: operation table, queue reference model and checks.
`timescale 1ns/100ps

module line_fifo_tb;

  localparam int DEPTH_LOG2     = 4;
  localparam int CORE_DEPTH     = 2 ** DEPTH_LOG2;
  localparam int STAGE_WORDS    = 3;  // Words the output stage can buffer.
  localparam int TIMEOUT_CYCLES = 50;
  localparam int NUM_OPS        = 22;

  // Operation kinds of the stimulus table.
  localparam logic [2:0] OP_WRITE  = 3'd0;
  localparam logic [2:0] OP_READ   = 3'd1;
  localparam logic [2:0] OP_HOLD   = 3'd2;
  localparam logic [2:0] OP_CFG_WR = 3'd3;
  localparam logic [2:0] OP_CFG_RD = 3'd4;

  typedef struct packed {
    logic [2:0]              kind;
    logic [7:0]              count;
    fifo_cfg_pkg::cfg_addr_t addr;
    logic [15:0]             value;      // Write data or expected read data.
    logic                    from_model; // Expected read data is the model level.
  } op_row_t;

  logic                   RD_CLK = 1'b0;
  logic                   RESET;
  logic                   wren;
  fifo_data_pkg::pixel_t  din;
  logic                   overflow;
  logic                   rden;
  fifo_data_pkg::pixel_t  dout;
  logic                   empty;
  logic                   full;
  logic                   cfg_req;
  logic                   cfg_ack;
  fifo_cfg_pkg::cfg_req_t cfg_cmd;
  fifo_cfg_pkg::cfg_rsp_t cfg_rsp;

  integer                  seed = 32'h57c61e03;
  fifo_data_pkg::pixel_t   model_q [$];  // Words expected on dout, oldest first.
  fifo_cfg_pkg::cfg_data_t model_thresh;
  op_row_t                 ops [0:NUM_OPS-1];
  logic [15:0]             rdata;

  always #5 RD_CLK = ~RD_CLK;

  line_fifo_top #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) line_fifo_top_inst (
    .RD_CLK   (RD_CLK),
    .RESET    (RESET),
    .wren     (wren),
    .din      (din),
    .overflow (overflow),
    .rden     (rden),
    .dout     (dout),
    .empty    (empty),
    .full     (full),
    .cfg_req  (cfg_req),
    .cfg_ack  (cfg_ack),
    .cfg_cmd  (cfg_cmd),
    .cfg_rsp  (cfg_rsp)
  );

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s.", $time, what);
    $display(">>> FAIL");
    $fatal(1, "Stopped after a timeout.");
  endtask

  // Words held in the core, assuming the output stage has filled up first.
  function automatic int core_level();
    if (model_q.size() > STAGE_WORDS) begin
      return model_q.size() - STAGE_WORDS;
    end
    return 0;
  endfunction

  function automatic op_row_t make_row(input logic [2:0] kind, input int count,
                                       input fifo_cfg_pkg::cfg_addr_t addr,
                                       input int value, input logic from_model);
    op_row_t row;
    row.kind       = kind;
    row.count      = count[7:0];
    row.addr       = addr;
    row.value      = value[15:0];
    row.from_model = from_model;
    return row;
  endfunction

  task automatic wait_not_empty();
    int cycles = 0;
    @(negedge RD_CLK);
    while (empty !== 1'b0) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout("empty to fall");
      @(negedge RD_CLK);
    end
  endtask

  task automatic wait_ack(input logic level, input string what);
    int cycles = 0;
    @(negedge RD_CLK);
    while (cfg_ack !== level) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout(what);
      @(negedge RD_CLK);
    end
  endtask

  // Let level and full catch up, then compare full with the model.
  task automatic settle_and_check_full();
    repeat (2) @(posedge RD_CLK);
    @(negedge RD_CLK);
    check_value(full, (model_q.size() >= model_thresh), "full against model level");
  endtask

  task automatic write_burst(input int count);
    fifo_data_pkg::pixel_t word;
    logic                  exp_drop;
    for (int i = 0; i < count; i++) begin
      word     = fifo_data_pkg::pixel_t'($random(seed));
      exp_drop = (core_level() == CORE_DEPTH); // Core hard full drops the word.
      @(posedge RD_CLK);
      wren <= 1'b1;
      din  <= word;
      @(negedge RD_CLK);
      check_value(overflow, exp_drop, "overflow pulse on write");
      if (!exp_drop) begin
        model_q.push_back(word);
      end
    end
    @(posedge RD_CLK);
    wren <= 1'b0;
    settle_and_check_full();
  endtask

  task automatic read_burst(input int count);
    for (int i = 0; i < count; i++) begin
      wait_not_empty();
      check_value(dout, model_q[0], "dout against model head");
      @(posedge RD_CLK);
      rden <= 1'b1;
      @(posedge RD_CLK);   // The pop happens at this edge.
      rden <= 1'b0;
      void'(model_q.pop_front());
      if ($random(seed) & 1) begin
        @(posedge RD_CLK); // Random gap between pops.
      end
    end
    settle_and_check_full();
  endtask

  task automatic hold_rden_low(input int count);
    fifo_data_pkg::pixel_t held_dout;
    logic                  held_empty;
    if (model_q.size() != 0) begin
      wait_not_empty();
      check_value(dout, model_q[0], "dout before hold");
    end else begin
      @(negedge RD_CLK);
    end
    held_dout  = dout;
    held_empty = empty;
    repeat (count) begin
      @(negedge RD_CLK);
      check_value(empty, held_empty, "empty under back-pressure");
      if (!held_empty) check_value(dout, held_dout, "dout under back-pressure");
    end
  endtask

  // One four-phase access. Read data is returned in rdata.
  task automatic cfg_access(input logic write, input fifo_cfg_pkg::cfg_addr_t addr,
                            input logic [15:0] wdata);
    fifo_cfg_pkg::cfg_req_t cmd;
    cmd.write = write;
    cmd.addr  = addr;
    cmd.wdata = wdata;
    @(posedge RD_CLK);
    cfg_req <= 1'b1;
    cfg_cmd <= cmd;
    wait_ack(1'b1, "cfg_ack to rise");
    rdata = cfg_rsp.rdata;
    @(posedge RD_CLK);
    cfg_req <= 1'b0;
    wait_ack(1'b0, "cfg_ack to fall");
  endtask

  initial begin
    RESET        <= 1'b1;
    wren         <= 1'b0;
    din          <= '0;
    rden         <= 1'b0;
    cfg_req      <= 1'b0;
    cfg_cmd      <= '0;
    model_thresh = fifo_cfg_pkg::THRESH_RESET;

    ops[0]  = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_THRESH, fifo_cfg_pkg::THRESH_RESET, 0);
    ops[1]  = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_LEVEL, 0, 1);
    ops[2]  = make_row(OP_WRITE, 5, 0, 0, 0);
    ops[3]  = make_row(OP_READ, 2, 0, 0, 0);
    ops[4]  = make_row(OP_WRITE, 9, 0, 0, 0);   // Level lands on the threshold.
    ops[5]  = make_row(OP_HOLD, 6, 0, 0, 0);
    ops[6]  = make_row(OP_READ, 4, 0, 0, 0);
    ops[7]  = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_LEVEL, 0, 1);
    ops[8]  = make_row(OP_WRITE, 9, 0, 0, 0);
    ops[9]  = make_row(OP_CFG_WR, 0, fifo_cfg_pkg::ADDR_THRESH, 8, 0);
    ops[10] = make_row(OP_READ, 9, 0, 0, 0);    // Back down to the new threshold.
    ops[11] = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_THRESH, 8, 0);
    ops[12] = make_row(OP_WRITE, 14, 0, 0, 0);  // Runs past 19 words, so 3 drop.
    ops[13] = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_LEVEL, 0, 1);
    ops[14] = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_STATUS, 1, 0);
    ops[15] = make_row(OP_CFG_WR, 0, fifo_cfg_pkg::ADDR_STATUS, 1, 0);
    ops[16] = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_STATUS, 0, 0);
    ops[17] = make_row(OP_HOLD, 5, 0, 0, 0);
    ops[18] = make_row(OP_READ, 19, 0, 0, 0);
    ops[19] = make_row(OP_CFG_RD, 0, fifo_cfg_pkg::ADDR_LEVEL, 0, 1);
    ops[20] = make_row(OP_WRITE, 3, 0, 0, 0);
    ops[21] = make_row(OP_READ, 3, 0, 0, 0);

    repeat (3) @(posedge RD_CLK);
    RESET <= 1'b0;
    @(negedge RD_CLK);
    check_value(empty, 1'b1, "empty after reset");
    check_value(full, 1'b0, "full after reset");
    check_value(cfg_ack, 1'b0, "cfg_ack after reset");

    for (int i = 0; i < NUM_OPS; i++) begin
      case (ops[i].kind)
        OP_WRITE: write_burst(ops[i].count);
        OP_READ:  read_burst(ops[i].count);
        OP_HOLD:  hold_rden_low(ops[i].count);
        OP_CFG_WR: begin
          cfg_access(1'b1, ops[i].addr, ops[i].value);
          if (ops[i].addr == fifo_cfg_pkg::ADDR_THRESH) model_thresh = ops[i].value;
          settle_and_check_full();
        end
        default: begin
          cfg_access(1'b0, ops[i].addr, '0);
          if (ops[i].from_model) begin
            check_value(rdata, model_q.size(), "level register against model");
          end else begin
            check_value(rdata, ops[i].value, "configuration read");
          end
        end
      endcase
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- line_fifo.f
fifo_data_pkg.sv
fifo_cfg_pkg.sv
fifo_ram.sv
fifo_core.sv
fifo_out_stage.sv
fifo_csr.sv
line_fifo_top.sv
line_fifo_tb.sv
